// File: hart_lite.f
+incdir+hw
hw/hart_pkg.sv
hw/inst_decoder.sv
hw/operand_fetch.sv
hw/alu_exec.sv
hw/fetch_unit.sv
hw/load_store_unit.sv
hw/bus_arbiter.sv
hw/hart_lite_top.sv
testbench/hart_checker.sv
testbench/tb_hart_lite.sv

// File: Makefile
# Verilator build and run for hart_lite
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_hart_lite
FILELIST  ?= hart_lite.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
PASS_TEXT ?= TEST PASS

SOURCES := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation opens testbench/hart_tests.txt relative to this directory
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -x "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/hart_tests.txt
# P <word address> <instruction word>, program image in hex
# S <byte address> <data>, expected bus writes in program order
P 00000000 123452b7  # lui  x5, 0x12345
P 00000004 67828293  # addi x5, x5, 0x678
P 00000008 00512023  # sw   x5, 0(x2)
P 0000000c fff2c313  # xori x6, x5, -1
P 00000010 0f037393  # andi x7, x6, 0xf0
P 00000014 7033e393  # ori  x7, x7, 0x703
P 00000018 40538433  # sub  x8, x7, x5
P 0000001c 00812223  # sw   x8, 4(x2)
P 00000020 007374b3  # and  x9, x6, x7
P 00000024 0054e533  # or   x10, x9, x5
P 00000028 008545b3  # xor  x11, x10, x8
P 0000002c 00b12423  # sw   x11, 8(x2)
P 00000030 00100613  # addi x12, x0, 1
P 00000034 00260613  # addi x12, x12, 2
P 00000038 00360613  # addi x12, x12, 3
P 0000003c ff660613  # addi x12, x12, -10
P 00000040 00c12623  # sw   x12, 12(x2)
P 00000044 00012683  # lw   x13, 0(x2)
P 00000048 00968733  # add  x14, x13, x9
P 0000004c 00e12823  # sw   x14, 16(x2)
P 00000050 00c12a23  # sw   x12, 20(x2)
P 00000054 01412783  # lw   x15, 20(x2)
P 00000058 00f12c23  # sw   x15, 24(x2)
P 0000005c 00000000  # zero word
P 00000060 ffffffff  # unknown opcode
P 00000064 00129293  # slli x5, x5, 1 is unsupported
P 00000068 00512e23  # sw   x5, 28(x2)
S 00004000 12345678
S 00004004 edcbb10b
S 00004008 ffffe6f0
S 0000400c fffffffc
S 00004010 123457fb
S 00004014 fffffffc
S 00004018 fffffffc
S 0000401c 12345678

// File: testbench/tb_hart_lite.sv
`timescale 1ns/1ps

module tb_hart_lite import hart_pkg::*; ();

	localparam int MAX_STORES   = 64;
	localparam int MEM_WORDS    = 16384;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 20;

	logic     clock_bus;
	logic     reset;
	logic     mem_done;
	word_t    mem_rdata;
	bus_req_t mem_req;

	// memory model storage and the staged program image
	word_t mem [MEM_WORDS];
	addr_t prog_addr [$];
	word_t prog_word [$];

	addr_t exp_addr [MAX_STORES];
	word_t exp_data [MAX_STORES];
	int    exp_count    = 0;
	int    prog_len     = 0;
	int    limit_cycles = 0;
	logic  tests_loaded = 1'b0;
	logic  load_failed  = 1'b0;
	logic  timed_out    = 1'b0;
	logic  run_over     = 1'b0;
	logic  final_check;
	logic  all_seen;
	logic  report_done;
	int    error_count;
	int    missing_count;

	hart_lite_top hart_lite_top_inst (
		.clock_bus_i (clock_bus),
		.reset_i     (reset),
		.mem_done_i  (mem_done),
		.mem_rdata_i (mem_rdata),
		.mem_req_o   (mem_req)
	);

	hart_checker #(.MAX_STORES(MAX_STORES)) hart_checker_inst (
		.clock_bus_i     (clock_bus),
		.reset_i         (reset),
		.mem_req_i       (mem_req),
		.exp_addr_i      (exp_addr),
		.exp_data_i      (exp_data),
		.exp_count_i     (exp_count),
		.final_check_i   (final_check),
		.all_seen_o      (all_seen),
		.report_done_o   (report_done),
		.error_count_o   (error_count),
		.missing_count_o (missing_count)
	);

	// 32 bit xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// P lines fill the program image and S lines the expected stores
	task automatic load_tests();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  kind;
		logic [31:0] a;
		logic [31:0] d;
		fd = $fopen("testbench/hart_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/hart_tests.txt");
			load_failed = 1'b1;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0) begin
					n = $sscanf(line, "%c %h %h", kind, a, d);
					if (n == 3 && kind == "P") begin
						prog_addr.push_back(a);
						prog_word.push_back(d);
						prog_len++;
					end else if (n == 3 && kind == "S" && exp_count < MAX_STORES) begin
						exp_addr[exp_count] = a;
						exp_data[exp_count] = d;
						exp_count++;
					end
				end
			end
			$fclose(fd);
			if (prog_len == 0 || exp_count == 0) begin
				$display("test file holds no program or no expected stores");
				load_failed = 1'b1;
			end
		end
	endtask

	initial begin
		clock_bus = 1'b0;
		forever #20 clock_bus = ~clock_bus;
	end

	// ------------------------------------------------------------------
	// memory model with one transfer at a time and done after 1 to 4 cycles
	// ------------------------------------------------------------------
	initial begin : memory_model
		int          wait_cycles;
		logic [31:0] rng;
		word_t       pend;
		mem_done    = 1'b0;
		mem_rdata   = '0;
		rng         = 32'h520f53e3;
		wait_cycles = 0;
		pend        = '0;
		// unwritten words carry their own index above an unknown opcode
		// so a stray fetch is a bubble and a stray load is easy to spot
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {i[24:0], 7'h7f};
		end
		wait (tests_loaded);
		foreach (prog_addr[i]) begin
			mem[prog_addr[i][15:2]] = prog_word[i];
		end
		forever begin
			@(negedge clock_bus);
			mem_done = 1'b0;
			if (wait_cycles > 0) begin
				wait_cycles--;
				if (wait_cycles == 0) begin
					mem_done  = 1'b1;
					mem_rdata = pend;
				end
			end
			if (reset && mem_req.strobe) begin
				rng         = xorshift32(rng);
				wait_cycles = int'(rng[1:0]) + 1;
				if (mem_req.we) begin
					mem[mem_req.addr[15:2]] = mem_req.wdata;
				end
				pend = mem[mem_req.addr[15:2]];
			end
		end
	end

	// watchdog budget scales with the program length
	initial begin : watchdog
		wait (tests_loaded && reset);
		repeat (limit_cycles) @(posedge clock_bus);
		if (!run_over) begin
			timed_out = 1'b1;
			$display("timeout: stores still missing after %0d cycles", limit_cycles);
		end
	end

	initial begin
		reset       = 1'b0;
		final_check = 1'b0;
		load_tests();
		limit_cycles = prog_len * 12 + 200;
		tests_loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock_bus);
		reset = 1'b1;
		if (!load_failed) begin
			wait (all_seen || timed_out);
			// extra cycles catch stray writes after the last store
			if (!timed_out) begin
				repeat (DRAIN_CYCLES) @(negedge clock_bus);
			end
		end
		run_over = 1'b1;
		@(negedge clock_bus);
		final_check = 1'b1;
		wait (report_done);
		$display("errors: %0d wrong, %0d missing, %0d timeout, %0d load", error_count,
			missing_count, timed_out ? 1 : 0, load_failed ? 1 : 0);
		if (error_count == 0 && missing_count == 0 && !timed_out && !load_failed) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: testbench/hart_checker.sv
`timescale 1ns/1ps

module hart_checker import hart_pkg::*; #(
	parameter int MAX_STORES = 64
) (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  bus_req_t mem_req_i,
	input  addr_t    exp_addr_i [MAX_STORES],
	input  word_t    exp_data_i [MAX_STORES],
	input  int       exp_count_i,
	input  logic     final_check_i,
	output logic     all_seen_o,
	output logic     report_done_o,
	output int       error_count_o,
	output int       missing_count_o
);

	int   seen;
	logic first_seen;

	assign all_seen_o = (exp_count_i > 0) && (seen >= exp_count_i);

	// ------------------------------------------------------------------
	// bus watch, the request is registered so mid cycle is stable
	// ------------------------------------------------------------------
	always @(negedge clock_bus_i) begin
		if (!reset_i) begin
			seen          = 0;
			first_seen    = 1'b0;
			error_count_o = 0;
		end else if (mem_req_i.strobe) begin
			// very first access must be the reset fetch
			if (!first_seen) begin
				first_seen = 1'b1;
				if (mem_req_i.we || mem_req_i.addr != '0) begin
					error_count_o++;
					$display("** Error at %0t: first bus access is a %s of %h, expected a read of 0",
						$time, mem_req_i.we ? "write" : "read", mem_req_i.addr);
				end
			end
			if (mem_req_i.we) begin
				if (seen >= exp_count_i) begin
					error_count_o++;
					$display("** Error at %0t: unexpected write of %h to %h",
						$time, mem_req_i.wdata, mem_req_i.addr);
				end else begin
					// stores must arrive in program order
					if (mem_req_i.addr != exp_addr_i[seen] ||
						mem_req_i.wdata != exp_data_i[seen]) begin
						error_count_o++;
						$display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
							$time, seen, mem_req_i.wdata, mem_req_i.addr,
							exp_data_i[seen], exp_addr_i[seen]);
					end
					seen++;
				end
			end
		end
	end

	// end of run, list whatever never showed up
	always @(posedge clock_bus_i) begin
		if (!reset_i) begin
			missing_count_o <= 0;
			report_done_o   <= 1'b0;
		end else if (final_check_i && !report_done_o) begin
			for (int i = seen; i < exp_count_i; i++) begin
				$display("expected store %0d of %h to %h was never written",
					i, exp_data_i[i], exp_addr_i[i]);
			end
			missing_count_o <= (exp_count_i > seen) ? exp_count_i - seen : 0;
			report_done_o   <= 1'b1;
		end
	end

endmodule

// File: hw/hart_lite_top.sv
`timescale 1ns/1ps

module hart_lite_top import hart_pkg::*; (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  logic     mem_done_i,
	input  word_t    mem_rdata_i,
	output bus_req_t mem_req_o
);

	bus_req_t fetch_req;
	bus_req_t data_req;
	logic     fetch_done;
	logic     data_done;
	word_t    bus_rdata;
	word_t    inst;
	logic     inst_valid;
	logic     mem_busy;
	logic     load_hold;
	logic     front_stall;
	issue_t   issue;
	exec_t    ex;
	wb_t      wb;

	// fetch freezes for either hold source
	assign front_stall = mem_busy | load_hold;

	// ------------------------------------------------------------------
	// pipeline
	// ------------------------------------------------------------------
	fetch_unit fetch_unit_inst (
		.clock_bus_i  (clock_bus_i),
		.reset_i      (reset_i),
		.stall_i      (front_stall),
		.done_i       (fetch_done),
		.rdata_i      (bus_rdata),
		.req_o        (fetch_req),
		.inst_o       (inst),
		.inst_valid_o (inst_valid)
	);

	operand_fetch operand_fetch_inst (
		.clock_bus_i  (clock_bus_i),
		.reset_i      (reset_i),
		.mem_busy_i   (mem_busy),
		.inst_i       (inst),
		.inst_valid_i (inst_valid),
		.ex_fwd_i     (ex),
		.wb_i         (wb),
		.exec_o       (issue),
		.load_hold_o  (load_hold)
	);

	alu_exec alu_exec_inst (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.stall_i     (mem_busy),
		.issue_i     (issue),
		.ex_o        (ex)
	);

	load_store_unit load_store_unit_inst (
		.clock_bus_i (clock_bus_i),
		.reset_i     (reset_i),
		.ex_i        (ex),
		.done_i      (data_done),
		.rdata_i     (bus_rdata),
		.req_o       (data_req),
		.busy_o      (mem_busy),
		.wb_o        (wb)
	);

	// single memory bus shared by both units
	bus_arbiter bus_arbiter_inst (
		.clock_bus_i  (clock_bus_i),
		.reset_i      (reset_i),
		.fetch_req_i  (fetch_req),
		.data_req_i   (data_req),
		.mem_done_i   (mem_done_i),
		.mem_rdata_i  (mem_rdata_i),
		.mem_req_o    (mem_req_o),
		.fetch_done_o (fetch_done),
		.data_done_o  (data_done),
		.rdata_o      (bus_rdata)
	);

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import hart_pkg::*; (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  bus_req_t fetch_req_i,
	input  bus_req_t data_req_i,
	input  logic     mem_done_i,
	input  word_t    mem_rdata_i,
	output bus_req_t mem_req_o,
	output logic     fetch_done_o,
	output logic     data_done_o,
	output word_t    rdata_o
);

	typedef enum logic [1:0] {ARB_IDLE, ARB_FETCH, ARB_DATA} owner_e;

	owner_e   owner;
	bus_req_t fetch_q;
	bus_req_t data_q;
	bus_req_t fetch_cur;
	bus_req_t data_cur;
	bus_req_t mem_req_q;

	// a live strobe or the one parked in the latch
	assign fetch_cur = fetch_req_i.strobe ? fetch_req_i : fetch_q;
	assign data_cur  = data_req_i.strobe ? data_req_i : data_q;

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			owner            <= ARB_IDLE;
			fetch_q.strobe   <= 1'b0;
			data_q.strobe    <= 1'b0;
			mem_req_q.strobe <= 1'b0;
		end else begin
			mem_req_q.strobe <= 1'b0;
			// park anything not granted this cycle
			fetch_q <= fetch_cur;
			data_q  <= data_cur;
			case (owner)
				ARB_IDLE: begin
					// data before fetch
					if (data_cur.strobe) begin
						mem_req_q     <= data_cur;
						owner         <= ARB_DATA;
						data_q.strobe <= 1'b0;
					end else if (fetch_cur.strobe) begin
						mem_req_q      <= fetch_cur;
						owner          <= ARB_FETCH;
						fetch_q.strobe <= 1'b0;
					end
				end
				default: if (mem_done_i) owner <= ARB_IDLE;
			endcase
		end
	end

	assign mem_req_o = mem_req_q;

	// done goes to the owner in the same cycle
	assign fetch_done_o = mem_done_i && (owner == ARB_FETCH);
	assign data_done_o  = mem_done_i && (owner == ARB_DATA);
	assign rdata_o      = mem_rdata_i;

	a_done_has_owner: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		mem_done_i |-> (owner != ARB_IDLE));

endmodule

// File: hw/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import hart_pkg::*; (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  exec_t    ex_i,
	input  logic     done_i,
	input  word_t    rdata_i,
	output bus_req_t req_o,
	output logic     busy_o,
	output wb_t      wb_o
);

	typedef enum logic {LSU_IDLE, LSU_WAIT} lsu_state_e;

	lsu_state_e state;
	wb_t        wb_q;
	logic       is_mem;

	assign is_mem = (ex_i.op == OP_LOAD) || (ex_i.op == OP_STORE);

	// strobe straight from the execute register once per item
	always_comb begin
		req_o.strobe = (state == LSU_IDLE) && is_mem;
		req_o.we     = (ex_i.op == OP_STORE);
		req_o.addr   = ex_i.result;
		req_o.wdata  = ex_i.store_data;
	end

	// high from the strobe cycle until the done cycle
	assign busy_o = ((state == LSU_IDLE) && is_mem) || ((state == LSU_WAIT) && !done_i);

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			state      <= LSU_IDLE;
			wb_q.valid <= 1'b0;
		end else begin
			case (state)
				LSU_IDLE: begin
					if (is_mem) begin
						state      <= LSU_WAIT;
						wb_q.valid <= 1'b0;
					end else begin
						wb_q.valid <= is_alu_op(ex_i.op);
						wb_q.rd    <= ex_i.rd;
						wb_q.value <= ex_i.result;
					end
				end
				LSU_WAIT: begin
					wb_q.valid <= 1'b0;
					if (done_i) begin
						// a store completes here with nothing to write back
						state      <= LSU_IDLE;
						wb_q.valid <= (ex_i.op == OP_LOAD);
						wb_q.rd    <= ex_i.rd;
						wb_q.value <= rdata_i;
					end
				end
				default: state <= LSU_IDLE;
			endcase
		end
	end

	assign wb_o = wb_q;

	// while waiting the item stays put and no second strobe goes out
	a_one_outstanding: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		(state == LSU_WAIT) |-> ($stable(ex_i) && !req_o.strobe));

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`include "hart_cfg.svh"

module fetch_unit import hart_pkg::*; (
	input  logic     clock_bus_i,
	input  logic     reset_i,
	input  logic     stall_i,
	input  logic     done_i,
	input  word_t    rdata_i,
	output bus_req_t req_o,
	output word_t    inst_o,
	output logic     inst_valid_o
);

	addr_t pc;
	logic  req_q;
	logic  pending;
	logic  valid_q;
	word_t inst_q;
	logic  take;

	// operand stage consumes the word when nothing holds it
	assign take = valid_q && !stall_i;

	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			pc      <= `HART_RESET_PC;
			req_q   <= 1'b0;
			pending <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			req_q <= 1'b0;
			if (done_i) begin
				// slot is always empty here, a request goes out only then
				inst_q  <= rdata_i;
				valid_q <= 1'b1;
				pending <= 1'b0;
				pc      <= pc + 4;
			end else if (take) begin
				valid_q <= 1'b0;
			end
			// one outstanding read, started once the slot frees up
			if (!pending && (!valid_q || take)) begin
				req_q   <= 1'b1;
				pending <= 1'b1;
			end
		end
	end

	always_comb begin
		req_o.strobe = req_q;
		req_o.we     = 1'b0;
		req_o.addr   = pc;
		req_o.wdata  = '0;
	end

	assign inst_o       = inst_q;
	assign inst_valid_o = valid_q;

endmodule

// File: hw/alu_exec.sv
`timescale 1ns/1ps

module alu_exec import hart_pkg::*; (
	input  logic   clock_bus_i,
	input  logic   reset_i,
	input  logic   stall_i,
	input  issue_t issue_i,
	output exec_t  ex_o
);

	word_t operand_b;
	exec_t ex_next;
	exec_t ex_q;

	always_comb begin
		operand_b          = issue_i.dec.use_imm ? issue_i.dec.imm : issue_i.rs2_val;
		ex_next.op         = issue_i.dec.op;
		ex_next.rd         = issue_i.dec.rd;
		ex_next.store_data = issue_i.rs2_val;
		case (issue_i.dec.op)
			// loads and stores form base plus offset on the adder
			OP_ADD, OP_LOAD, OP_STORE: ex_next.result = issue_i.rs1_val + operand_b;
			OP_SUB: ex_next.result = issue_i.rs1_val - operand_b;
			OP_AND: ex_next.result = issue_i.rs1_val & operand_b;
			OP_OR:  ex_next.result = issue_i.rs1_val | operand_b;
			OP_XOR: ex_next.result = issue_i.rs1_val ^ operand_b;
			OP_LUI: ex_next.result = issue_i.dec.imm;
			default: ex_next.result = '0;
		endcase
	end

	// execute-to-memory register, also the first forwarding source
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			ex_q.op <= OP_NONE;
			ex_q.rd <= '0;
		end else if (!stall_i) begin
			ex_q <= ex_next;
		end
	end

	assign ex_o = ex_q;

endmodule

// File: hw/operand_fetch.sv
`timescale 1ns/1ps
`include "hart_cfg.svh"

module operand_fetch import hart_pkg::*; (
	input  logic   clock_bus_i,
	input  logic   reset_i,
	input  logic   mem_busy_i,
	input  word_t  inst_i,
	input  logic   inst_valid_i,
	input  exec_t  ex_fwd_i,
	input  wb_t    wb_i,
	output issue_t exec_o,
	output logic   load_hold_o
);

	word_t    rf [`HART_NREGS];
	decoded_t dec_new;
	decoded_t dec_q;
	word_t    rs1_val;
	word_t    rs2_val;

	// youngest producer wins: execute item first, then writeback, then the file
	function automatic word_t pick_operand(
		input reg_idx_t idx,
		input word_t    rf_val,
		input exec_t    ex,
		input wb_t      wb
	);
		if (idx == '0)
			return '0;
		if (is_alu_op(ex.op) && ex.rd == idx)
			return ex.result;
		if (wb.valid && wb.rd == idx)
			return wb.value;
		return rf_val;
	endfunction

	inst_decoder inst_decoder_inst (
		.inst_i (inst_i),
		.dec_o  (dec_new)
	);

	// ------------------------------------------------------------------
	// integer register file, written at the edge where wb_i is valid
	// ------------------------------------------------------------------
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			for (int i = 0; i < `HART_NREGS; i++) begin
				rf[i] <= (i == 2) ? `HART_SP_BASE : '0;
			end
		end else if (wb_i.valid && wb_i.rd != '0) begin
			rf[wb_i.rd] <= wb_i.value;
		end
	end

	// decode-to-execute register
	// an empty fetch slot enters as a bubble
	always_ff @(posedge clock_bus_i) begin
		if (!reset_i) begin
			dec_q <= '0;
		end else if (!mem_busy_i && !load_hold_o) begin
			dec_q <= inst_valid_i ? dec_new : '0;
		end
	end

	// operands are read while the item sits in the register
	assign rs1_val = pick_operand(dec_q.rs1, rf[dec_q.rs1], ex_fwd_i, wb_i);
	assign rs2_val = pick_operand(dec_q.rs2, rf[dec_q.rs2], ex_fwd_i, wb_i);

	// load data is not back yet, wait one slot for it on writeback
	assign load_hold_o = (ex_fwd_i.op == OP_LOAD) && (ex_fwd_i.rd != '0) &&
		((ex_fwd_i.rd == dec_q.rs1) || (ex_fwd_i.rd == dec_q.rs2));

	always_comb begin
		exec_o.dec     = dec_q;
		exec_o.rs1_val = rs1_val;
		exec_o.rs2_val = rs2_val;
		// held item is repeated later, execute sees a bubble now
		if (load_hold_o) begin
			exec_o.dec.op = OP_NONE;
			exec_o.dec.rd = '0;
		end
	end

	// x0 stays zero whatever the writeback path delivers
	a_x0_zero: assert property (@(posedge clock_bus_i) disable iff (!reset_i)
		rf[0] == '0);

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/1ps
`include "hart_cfg.svh"

module inst_decoder import hart_pkg::*; (
	input  word_t    inst_i,
	output decoded_t dec_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_u;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	// sign extended I and S forms, U keeps the low 12 bits clear
	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_u = {inst_i[31:12], 12'b0};

	// shared funct3 map of OP and OP-IMM, shifts and compares are not supported
	function automatic alu_op_e logic_op(input logic [2:0] f3);
		case (f3)
			3'b000: return OP_ADD;
			3'b100: return OP_XOR;
			3'b110: return OP_OR;
			3'b111: return OP_AND;
			default: return OP_NONE;
		endcase
	endfunction

	always_comb begin
		dec_o = '0;
		// first pick the operation
		case (opcode)
			`HART_OPC_LUI: dec_o.op = OP_LUI;
			`HART_OPC_OPIMM: dec_o.op = logic_op(funct3);
			`HART_OPC_OP: begin
				if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					dec_o.op = OP_SUB;
				end else if (funct7 == 7'b0000000) begin
					dec_o.op = logic_op(funct3);
				end
			end
			// word access only
			`HART_OPC_LOAD: if (funct3 == 3'b010) dec_o.op = OP_LOAD;
			`HART_OPC_STORE: if (funct3 == 3'b010) dec_o.op = OP_STORE;
			default: dec_o.op = OP_NONE;
		endcase
		// then fill only the fields that op really uses
		case (dec_o.op)
			OP_NONE: dec_o.use_imm = 1'b0;
			OP_LUI: begin
				dec_o.rd      = inst_i[11:7];
				dec_o.imm     = imm_u;
				dec_o.use_imm = 1'b1;
			end
			OP_STORE: begin
				dec_o.rs1     = inst_i[19:15];
				dec_o.rs2     = inst_i[24:20];
				dec_o.imm     = imm_s;
				dec_o.use_imm = 1'b1;
			end
			default: begin
				dec_o.rd  = inst_i[11:7];
				dec_o.rs1 = inst_i[19:15];
				// register form reads rs2, immediate and load forms take imm_i
				if (opcode == `HART_OPC_OP) begin
					dec_o.rs2 = inst_i[24:20];
				end else begin
					dec_o.imm     = imm_i;
					dec_o.use_imm = 1'b1;
				end
			end
		endcase
	end

	// a bubble must never reach writeback with a destination
	always_comb begin
		a_bubble_no_rd: assert (dec_o.op != OP_NONE || dec_o.rd == '0)
			else $error("decoder bubble carries rd %0d", dec_o.rd);
	end

endmodule

// File: hw/hart_pkg.sv
`include "hart_cfg.svh"

package hart_pkg;

	typedef logic [`HART_XLEN-1:0] word_t;
	typedef logic [`HART_XLEN-1:0] addr_t;
	typedef logic [$clog2(`HART_NREGS)-1:0] reg_idx_t;

	// OP_NONE must stay at zero, a cleared struct is a bubble
	typedef enum logic [3:0] {
		OP_NONE  = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUB   = 4'd2,
		OP_AND   = 4'd3,
		OP_OR    = 4'd4,
		OP_XOR   = 4'd5,
		OP_LUI   = 4'd6,
		OP_LOAD  = 4'd7,
		OP_STORE = 4'd8
	} alu_op_e;

	// unused source fields are left at x0
	typedef struct packed {
		alu_op_e  op;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t    imm;
		logic     use_imm;
	} decoded_t;

	// decoded item plus its resolved operands, input of execute
	typedef struct packed {
		decoded_t dec;
		word_t    rs1_val;
		word_t    rs2_val;
	} issue_t;

	typedef struct packed {
		alu_op_e  op;
		reg_idx_t rd;
		word_t    result;
		word_t    store_data;
	} exec_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    value;
	} wb_t;

	typedef struct packed {
		logic  strobe;
		logic  we;
		addr_t addr;
		word_t wdata;
	} bus_req_t;

	// ops whose result goes back to the register file straight from execute
	function automatic logic is_alu_op(input alu_op_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LUI};
	endfunction

endpackage

// File: hw/hart_cfg.svh
`ifndef HART_CFG_SVH
`define HART_CFG_SVH

// datapath and register file geometry
`define HART_XLEN     32
`define HART_NREGS    32

// x2 comes out of reset pointing at the top of the stack
`define HART_SP_BASE  32'h0000_4000
`define HART_RESET_PC 32'h0000_0000

// major opcodes that the decoder recognises
`define HART_OPC_LUI   7'b0110111
`define HART_OPC_OPIMM 7'b0010011
`define HART_OPC_OP    7'b0110011
`define HART_OPC_LOAD  7'b0000011
`define HART_OPC_STORE 7'b0100011

`endif
